// ==== hdl/fifo_lab_pkg.sv ====
package fifo_lab_pkg;

    // one queued value, also one hex digit on the display
    typedef logic [3:0] nibble_t;

    // segment pattern abcdefgh, h is the dot, 1 lights the segment
    typedef logic [7:0] seg_t;

    // push sequence, indexed by the accepted push count mod 16
    localparam nibble_t pattern_table [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    localparam seg_t sign_empty_head  = 8'b1111_0000;
    localparam seg_t sign_empty_entry = 8'b1001_0000;

    // standard hex glyphs with the dot off
    function automatic seg_t hex_to_seg(input nibble_t value);
        case (value)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

// ==== hdl/fifo_view_if.sv ====
`timescale 1ns/100ps

// continuous view of the FIFO contents, head first
interface fifo_view_if #(
    parameter depth = 8
);

    // bit i set when entry i counted from the head is occupied
    logic                                valid;
    logic [depth - 1:0]                  valid_mask;
    fifo_lab_pkg::nibble_t [depth - 1:0] data;
    logic                                empty;
    logic                                full;

    assign valid = |valid_mask;

    modport fifo (
        output valid_mask, data, empty, full,
        input  valid
    );

    modport display (
        input valid_mask, data, empty, full, valid
    );

endinterface

// ==== hdl/pattern_source.sv ====
`timescale 1ns/100ps

module pattern_source #(
    parameter depth = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             push_req,
    output logic                             push_valid,
    output fifo_lab_pkg::nibble_t            push_data,
    input  logic                             credit_return,
    output logic [$clog2(depth + 1) - 1:0]   credits
);

    localparam w_credit = $clog2(depth + 1);

    logic [3:0] pattern_idx;
    logic       accept;

    // a request without credit is simply dropped
    assign accept = push_req && (credits != '0);

    //--------------------------------------------------
    // control state

    always_ff @(posedge clk) begin
        if (rst) begin
            push_valid  <= 1'b0;
            pattern_idx <= '0;
            credits     <= w_credit'(depth);
        end else begin
            push_valid <= accept;

            // index counts accepted pushes only, wraps after 16
            if (accept) begin
                pattern_idx <= pattern_idx + 4'd1;
            end

            // spend on push, restore on return, both at once cancel
            case ({accept, credit_return})
                2'b10:   credits <= credits - w_credit'(1);
                2'b01:   credits <= credits + w_credit'(1);
                default: credits <= credits;
            endcase
        end
    end

    //--------------------------------------------------
    // payload

    always_ff @(posedge clk) begin
        if (accept) begin
            push_data <= fifo_lab_pkg::pattern_table[pattern_idx];
        end
    end

endmodule

// ==== hdl/flop_fifo_debug.sv ====
`timescale 1ns/100ps

module flop_fifo_debug #(
    parameter depth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_valid,
    input  fifo_lab_pkg::nibble_t push_data,
    output logic                  credit_return,
    input  logic                  pop_req,
    output logic                  pop_valid,
    output fifo_lab_pkg::nibble_t pop_data,
    fifo_view_if.fifo             view
);

    localparam w_ptr = $clog2(depth);
    localparam w_cnt = $clog2(depth + 1);

    fifo_lab_pkg::nibble_t mem [depth];

    logic [w_ptr - 1:0] wr_ptr;
    logic [w_ptr - 1:0] rd_ptr;
    logic [w_cnt - 1:0] cnt;
    logic               pop;

    // depth need not be a power of two
    function automatic logic [w_ptr - 1:0] next_ptr(input logic [w_ptr - 1:0] ptr);
        if (ptr == w_ptr'(depth - 1))
            return '0;
        else
            return ptr + w_ptr'(1);
    endfunction

    // no full check on writes, the source credits keep room
    assign pop = pop_req && (cnt != '0);

    //--------------------------------------------------
    // pointers, occupancy, pop pulse

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            cnt       <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= pop;
            if (push_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            cnt <= cnt + w_cnt'(push_valid) - w_cnt'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push_valid)
            mem[wr_ptr] <= push_data;
        if (pop)
            pop_data <= mem[rd_ptr];
    end

    // each freed entry hands one credit back
    assign credit_return = pop_valid;

    //--------------------------------------------------
    // debug view rotated so entry 0 is the head

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            view.data[i]       = mem[(int'(rd_ptr) + i) % depth];
            view.valid_mask[i] = (i < int'(cnt));
        end
    end

    assign view.empty = (cnt == '0);
    assign view.full  = (cnt == w_cnt'(depth));

endmodule

// ==== hdl/digit_scanner.sv ====
`timescale 1ns/100ps

module digit_scanner #(
    parameter depth       = 8,
    parameter refresh_div = 1024
) (
    input  logic               clk,
    input  logic               rst,
    fifo_view_if.display       view,
    output fifo_lab_pkg::seg_t abcdefgh,
    output logic [depth - 1:0] digit
);

    localparam w_div = (refresh_div > 1) ? $clog2(refresh_div) : 1;

    logic [w_div - 1:0]    div_cnt;
    logic                  tick;
    fifo_lab_pkg::nibble_t sel_data;
    logic                  sel_valid;
    fifo_lab_pkg::seg_t    hex_seg;

    //--------------------------------------------------
    // refresh prescaler and digit rotation

    assign tick = (div_cnt == w_div'(refresh_div - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            digit   <= depth'(1);
        end else if (tick) begin
            div_cnt <= '0;
            // rotate upward, wrap from the top digit back to 0
            digit   <= {digit[depth - 2:0], digit[depth - 1]};
        end else begin
            div_cnt <= div_cnt + w_div'(1);
        end
    end

    //--------------------------------------------------
    // pick the entry under the active digit

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < depth; i++) begin
            if (digit[i])
                sel_data = sel_data | view.data[i];
        end
    end

    assign sel_valid = |(digit & view.valid_mask);

    // dot lit on every digit while the FIFO is full
    assign hex_seg = fifo_lab_pkg::hex_to_seg(sel_data) | {7'b0, view.full};

    //--------------------------------------------------
    // glyph override, head-empty first

    always_comb begin
        if (digit[0] && view.empty)
            abcdefgh = fifo_lab_pkg::sign_empty_head;
        else if (!sel_valid)
            abcdefgh = fifo_lab_pkg::sign_empty_entry;
        else
            abcdefgh = hex_seg;
    end

endmodule

// ==== hdl/fifo_lab_top.sv ====
`timescale 1ns/100ps

module fifo_lab_top #(
    parameter depth       = 8,
    parameter refresh_div = 1024
) (
    input  logic                           clk,
    input  logic                           rst,
    // key 1 pushes, key 0 pops
    input  logic [1:0]                     key,
    output logic [$clog2(depth + 1) - 1:0] led,
    output logic                           pop_valid,
    output logic [3:0]                     pop_data,
    output logic [7:0]                     abcdefgh,
    output logic [depth - 1:0]             digit
);

    // push link
    logic                  push_valid;
    fifo_lab_pkg::nibble_t push_data;
    logic                  credit_return;

    fifo_view_if #(.depth(depth)) view ();

    //--------------------------------------------------
    // three pipeline stages

    pattern_source #(
        .depth (depth)
    ) i_source (
        .clk           (clk),
        .rst           (rst),
        .push_req      (key[1]),
        .push_valid    (push_valid),
        .push_data     (push_data),
        .credit_return (credit_return),
        .credits       (led)
    );

    flop_fifo_debug #(
        .depth (depth)
    ) i_fifo (
        .clk           (clk),
        .rst           (rst),
        .push_valid    (push_valid),
        .push_data     (push_data),
        .credit_return (credit_return),
        .pop_req       (key[0]),
        .pop_valid     (pop_valid),
        .pop_data      (pop_data),
        .view          (view.fifo)
    );

    digit_scanner #(
        .depth       (depth),
        .refresh_div (refresh_div)
    ) i_scanner (
        .clk      (clk),
        .rst      (rst),
        .view     (view.display),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

// ==== bench/fifo_lab_chk.sv ====
`timescale 1ns/100ps

module fifo_lab_chk #(
    parameter depth = 8
) (
    input logic                           clk,
    input logic                           rst,
    input logic                           push_valid,
    input logic [$clog2(depth + 1) - 1:0] credits,
    input logic [$clog2(depth + 1) - 1:0] occupancy,
    input logic                           credit_return,
    input logic                           pop_valid,
    input logic [depth - 1:0]             digit
);

    int error_count = 0;

    // a push needs a credit at the edge that accepted it
    push_needs_credit: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> $past(credits) != '0)
        else begin $error("push_valid issued with zero credits"); error_count++; end

    credits_in_range: assert property (@(posedge clk) disable iff (rst)
        credits <= depth)
        else begin $error("credit count above depth"); error_count++; end

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        occupancy <= depth)
        else begin $error("FIFO occupancy above depth"); error_count++; end

    credit_with_pop: assert property (@(posedge clk) disable iff (rst)
        credit_return == pop_valid)
        else begin $error("credit_return differs from pop_valid"); error_count++; end

    digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(digit))
        else begin $error("digit select not one-hot"); error_count++; end

endmodule

bind fifo_lab_top fifo_lab_chk #(
    .depth (depth)
) chk (
    .clk           (clk),
    .rst           (rst),
    .push_valid    (push_valid),
    .credits       (led),
    .occupancy     (i_fifo.cnt),
    .credit_return (credit_return),
    .pop_valid     (pop_valid),
    .digit         (digit)
);

// ==== bench/fifo_lab_tb.sv ====
`timescale 1ns/100ps

module fifo_lab_tb;

    localparam depth       = 8;
    localparam refresh_div = 4;

    localparam int reset_cycles   = 16;
    localparam int burst_long     = 60;
    localparam int burst_short    = 40;
    localparam int mix_cycles     = 350;
    localparam int drain_cycles   = 20;
    // the run takes about 600 cycles, the limit leaves a wide margin
    localparam int timeout_cycles = 2000;

    // push order of the pattern source
    localparam logic [3:0] push_seq [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // hex glyphs abcdefgh with the dot off
    localparam logic [7:0] glyph [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    localparam logic [7:0] empty_head_seg  = 8'b1111_0000;
    localparam logic [7:0] empty_entry_seg = 8'b1001_0000;

    logic                           clk;
    logic                           rst;
    logic [1:0]                     key;
    logic [$clog2(depth + 1) - 1:0] led;
    logic                           pop_valid;
    logic [3:0]                     pop_data;
    logic [7:0]                     abcdefgh;
    logic [depth - 1:0]             digit;

    // reference model state
    fifo_lab_pkg::nibble_t m_q[$];
    fifo_lab_pkg::nibble_t m_pend_data;
    fifo_lab_pkg::nibble_t m_pop_data;
    fifo_lab_pkg::seg_t    exp_seg;
    bit                    m_pend_valid;
    bit                    m_pop_valid;
    bit                    m_accept;
    bit                    m_pop;
    int                    m_credits;
    int                    m_idx;
    int                    m_div;
    int                    m_sel;
    int                    idle_edges;
    int                    cycle_count;

    fifo_lab_top #(
        .depth       (depth),
        .refresh_div (refresh_div)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .led       (led),
        .pop_valid (pop_valid),
        .pop_data  (pop_data),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else
            abort_run($sformatf("MISMATCH at %0t ns: %s expected %0h, got %0h",
                                $time, name, exp, act));
    endtask

    // random keys, each bit only where the phase allows it
    task automatic drive_keys(input int cycles, input bit push_on, input bit pop_on);
        repeat (cycles) begin
            @(posedge clk);
            key[1] <= push_on && ($urandom % 2 == 1);
            key[0] <= pop_on && ($urandom % 2 == 1);
        end
    endtask

    //--------------------------------------------------
    // reference model, one step per clock edge

    always @(posedge clk) begin
        if (rst) begin
            m_q.delete();
            m_credits    = depth;
            m_idx        = 0;
            m_div        = 0;
            m_sel        = 0;
            m_pend_valid = 1'b0;
            m_pop_valid  = 1'b0;
            idle_edges   = 0;
        end else begin
            m_accept = key[1] && (m_credits > 0);
            m_pop    = key[0] && (m_q.size() > 0);
            // a pop of the previous cycle hands its credit back now
            if (m_pop_valid)
                m_credits++;
            if (m_accept)
                m_credits--;
            m_pop_valid = m_pop;
            if (m_pop)
                m_pop_data = m_q.pop_front();
            if (m_pend_valid)
                m_q.push_back(m_pend_data);
            m_pend_valid = m_accept;
            if (m_accept) begin
                m_pend_data = push_seq[m_idx % 16];
                m_idx++;
            end
            // each digit stays selected for refresh_div cycles
            if (m_div == refresh_div - 1) begin
                m_div = 0;
                m_sel = (m_sel + 1) % depth;
            end else begin
                m_div++;
            end
            idle_edges = (key == 2'b00) ? idle_edges + 1 : 0;
        end
    end

    //--------------------------------------------------
    // compare on the falling edge where outputs are settled

    always @(negedge clk) begin
        if (!rst) begin
            expect_value("pop_valid", m_pop_valid, pop_valid);
            if (m_pop_valid)
                expect_value("pop_data", m_pop_data, pop_data);
            expect_value("led", m_credits, led);
            if (idle_edges >= 2)
                expect_value("led settled", depth - m_q.size(), led);
            expect_value("digit", 1 << m_sel, digit);
            if (m_q.size() == 0 && m_sel == 0) begin
                exp_seg = empty_head_seg;
            end else if (m_sel >= m_q.size()) begin
                exp_seg = empty_entry_seg;
            end else begin
                exp_seg = glyph[m_q[m_sel]];
                // all dots light while every entry is taken
                if (m_q.size() == depth)
                    exp_seg[0] = 1'b1;
            end
            expect_value($sformatf("abcdefgh digit %0d", m_sel), exp_seg, abcdefgh);
            assert (dut.chk.error_count == 0) else
                abort_run("a bound protocol assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
            abort_run("timeout, the run did not finish within the cycle limit");
    end

    initial begin
        cycle_count = 0;
        void'($urandom(32'h0785ab60));
        rst         = 1'b1;
        key         = 2'b00;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        drive_keys(burst_long, 1'b1, 1'b0);
        drive_keys(burst_long, 1'b0, 1'b1);
        drive_keys(burst_short, 1'b1, 1'b0);
        drive_keys(burst_short, 1'b0, 1'b1);
        drive_keys(mix_cycles, 1'b1, 1'b1);
        drive_keys(drain_cycles, 1'b0, 1'b0);

        @(negedge clk);
        if (dut.chk.error_count != 0) begin
            abort_run("a bound protocol assertion failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== build.f ====
hdl/fifo_lab_pkg.sv
hdl/fifo_view_if.sv
hdl/pattern_source.sv
hdl/flop_fifo_debug.sv
hdl/digit_scanner.sv
hdl/fifo_lab_top.sv
bench/fifo_lab_chk.sv
bench/fifo_lab_tb.sv
